//--- logic/i2c_pkg.sv
/*
 * I2C bus definitions: one bus byte and the byte-level
 * command set shared by the sequencer and the bit engine
 */
`default_nettype none

package i2c_pkg;

	// one byte as it travels on SDA, msb first
	typedef logic [7:0] bus_byte_t;

	// byte-level commands executed by the bit engine
	typedef enum logic [2:0] {
		CMD_IDLE  = 3'd0,	// nothing requested
		CMD_START = 3'd1,	// start or repeated start
		CMD_WRITE = 3'd2,	// eight bits out, ack in
		CMD_READ  = 3'd3,	// eight bits in, ack out
		CMD_STOP  = 3'd4	// stop condition
	} byte_cmd_t;

endpackage

`default_nettype wire

//--- logic/eeprom_pkg.sv
/*
 * 24LC04 memory map, record and slot types,
 * control byte and word address helpers
 */
`default_nettype none

package eeprom_pkg;

	localparam int RECORD_BYTES = 10;	// bytes per stored record
	localparam int SLOT_COUNT   = 32;	// slots over both blocks
	localparam int SLOT_STRIDE  = 16;	// memory bytes per slot
	localparam int BLOCK_BYTES  = 256;	// one device block

	localparam int SLOTS_PER_BLOCK = BLOCK_BYTES / SLOT_STRIDE;

	localparam logic [3:0] DEVICE_CODE = 4'b1010;	// fixed 24xx prefix

	// first byte on the bus sits in the top byte
	typedef logic [RECORD_BYTES*8-1:0] record_t;

	typedef logic [$clog2(SLOT_COUNT)-1:0] slot_t;

	// control byte: code, two zero bits, block bit, r/w
	function automatic logic [7:0] control_byte(input slot_t slot, input logic rd);
		logic block_bit;
		block_bit = (int'(slot) / SLOTS_PER_BLOCK) != 0;
		return {DEVICE_CODE, 2'b00, block_bit, rd};
	endfunction

	// word address of a slot inside its block
	function automatic logic [7:0] word_addr(input slot_t slot);
		return 8'((int'(slot) % SLOTS_PER_BLOCK) * SLOT_STRIDE);
	endfunction

endpackage

`default_nettype wire

//--- logic/i2c_byte_if.sv
/*
 * Byte command channel between the record sequencer and the I2C bit engine
 */
`timescale 1ns/1ps
`default_nettype none

interface i2c_byte_if;

	i2c_pkg::byte_cmd_t cmd;	// one-cycle strobe, engine idle
	i2c_pkg::bus_byte_t tx_byte;	// byte for CMD_WRITE
	logic               ack_out;	// 1 = acknowledge after CMD_READ

	logic               done;	// one-cycle completion pulse
	i2c_pkg::bus_byte_t rx_byte;	// byte from CMD_READ, valid with done
	logic               nack;	// slave did not acknowledge, valid with done

	modport seq (
		output cmd,
		output tx_byte,
		output ack_out,
		input  done,
		input  rx_byte,
		input  nack
	);

	modport eng (
		input  cmd,
		input  tx_byte,
		input  ack_out,
		output done,
		output rx_byte,
		output nack
	);

endinterface

`default_nettype wire

//--- logic/i2c_bit_engine.sv
/*
 * I2C bit engine: quarter-phase SCL generation, open-drain SDA drive,
 * execution of start, write, read and stop byte commands
 */
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine #(
	parameter int CLK_DIV = 62	// clk cycles per quarter SCL period
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic sda_in,
	output logic      scl,
	output logic      sda_oe,
	i2c_byte_if.eng   eng
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);

	logic [DIV_W-1:0]   div_cnt;
	logic [1:0]         quarter;	// 0,1 scl low; 2,3 scl high
	logic [3:0]         bit_cnt;	// 8 is the ack bit
	logic               active;
	logic               tick;
	logic               last_period;
	logic               oe_bit;	// drive for the low-phase update
	logic               ack_q;
	i2c_pkg::byte_cmd_t cur_cmd;
	i2c_pkg::bus_byte_t shreg;

	assign tick        = active && (div_cnt == DIV_W'(CLK_DIV - 1));
	assign last_period = (cur_cmd == i2c_pkg::CMD_START) || (cur_cmd == i2c_pkg::CMD_STOP) ||
			(bit_cnt == 4'd8);
	assign eng.rx_byte = shreg;

	// SDA level for the coming bit, set in the middle of scl low
	always_comb
	begin
		case (cur_cmd)
			i2c_pkg::CMD_START: oe_bit = 1'b0;	// release so sda is high first
			i2c_pkg::CMD_STOP:  oe_bit = 1'b1;	// pull low before the rising edge
			i2c_pkg::CMD_WRITE: oe_bit = (bit_cnt < 4'd8) ? ~shreg[7] : 1'b0;
			i2c_pkg::CMD_READ:  oe_bit = (bit_cnt < 4'd8) ? 1'b0 : ack_q;
			default:            oe_bit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scl      <= 1'b1;
			sda_oe   <= 1'b0;
			active   <= 1'b0;
			cur_cmd  <= i2c_pkg::CMD_IDLE;
			div_cnt  <= '0;
			quarter  <= 2'd0;
			bit_cnt  <= 4'd0;
			eng.done <= 1'b0;
			eng.nack <= 1'b0;
		end
		else
		begin
			eng.done <= 1'b0;
			if (!active)
			begin
				if (eng.cmd != i2c_pkg::CMD_IDLE)
				begin
					active  <= 1'b1;
					cur_cmd <= eng.cmd;
					div_cnt <= '0;
					quarter <= 2'd0;
					bit_cnt <= 4'd0;
					scl     <= 1'b0;	// first low phase
				end
			end
			else if (tick)
			begin
				div_cnt <= '0;
				quarter <= quarter + 2'd1;
				case (quarter)
					2'd0: sda_oe <= oe_bit;
					2'd1: scl <= 1'b1;
					2'd2:
					begin
						// mid-high: start/stop edges and ack sampling
						if (cur_cmd == i2c_pkg::CMD_START)
							sda_oe <= 1'b1;
						else if (cur_cmd == i2c_pkg::CMD_STOP)
							sda_oe <= 1'b0;
						else if (bit_cnt == 4'd8)
							eng.nack <= (cur_cmd == i2c_pkg::CMD_WRITE) && sda_in;
					end
					default:
					begin
						if (last_period)
						begin
							active   <= 1'b0;	// scl stays high when idle
							eng.done <= 1'b1;
						end
						else
						begin
							bit_cnt <= bit_cnt + 4'd1;
							scl     <= 1'b0;
						end
					end
				endcase
			end
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// byte shifter, tx out of the top, rx into the bottom
	always_ff @(posedge clk)
	begin
		if (!active && eng.cmd != i2c_pkg::CMD_IDLE)
		begin
			shreg <= eng.tx_byte;
			ack_q <= eng.ack_out;
		end
		else if (tick && quarter == 2'd2 && bit_cnt < 4'd8 &&
				(cur_cmd == i2c_pkg::CMD_WRITE || cur_cmd == i2c_pkg::CMD_READ))
			shreg <= {shreg[6:0], sda_in};
	end

	// sequencer keeps only one command in flight
	assert property (@(posedge clk) disable iff (!rst_n)
		active |-> eng.cmd == i2c_pkg::CMD_IDLE);

	// data may only move under a high clock for start and stop
	assert property (@(posedge clk) disable iff (!rst_n)
		(sda_oe != $past(sda_oe)) && $past(scl) |->
			(cur_cmd == i2c_pkg::CMD_START || cur_cmd == i2c_pkg::CMD_STOP));

endmodule

`default_nettype wire

//--- logic/record_sequencer.sv
/*
 * Record sequencer: page write and random read of 10-byte records,
 * slot pointer, retry after NACK and output record assembly
 */
`timescale 1ns/1ps
`default_nettype none

module record_sequencer (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 write_start,
	input  wire logic                 read_start,
	input  wire eeprom_pkg::record_t  data_in,
	output logic                      busy,
	output logic                      end_o,
	output eeprom_pkg::record_t       data_out,
	i2c_byte_if.seq                   seq
);

	typedef logic [$clog2(eeprom_pkg::RECORD_BYTES)-1:0] byte_idx_t;

	localparam byte_idx_t LAST_BYTE = byte_idx_t'(eeprom_pkg::RECORD_BYTES - 1);
	localparam eeprom_pkg::slot_t LAST_SLOT = eeprom_pkg::slot_t'(eeprom_pkg::SLOT_COUNT - 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_START,
		S_CTRL,	// control byte, write direction
		S_ADDR,
		S_WDATA,
		S_RESTART,
		S_CTRL_RD,
		S_RDATA,
		S_STOP
	} state_t;

	state_t              state;
	logic                pending;	// command issued, waiting for done
	logic                is_read;
	logic                retry;	// stop closes an aborted attempt
	logic                issue_now;
	logic                abort;
	byte_idx_t           byte_cnt;
	eeprom_pkg::slot_t   wr_slot;
	eeprom_pkg::slot_t   rd_slot;	// last slot written
	eeprom_pkg::slot_t   xact_slot;
	eeprom_pkg::record_t wr_rec;
	eeprom_pkg::record_t rd_rec;
	i2c_pkg::byte_cmd_t  issue_cmd;
	i2c_pkg::bus_byte_t  issue_byte;

	assign xact_slot = is_read ? rd_slot : wr_slot;
	assign issue_now = (state != S_IDLE) && !pending;
	assign abort     = seq.nack && (state == S_CTRL || state == S_ADDR ||
			state == S_WDATA || state == S_CTRL_RD);

	// command and byte belonging to each step
	always_comb
	begin
		issue_cmd  = i2c_pkg::CMD_IDLE;
		issue_byte = '0;
		case (state)
			S_START, S_RESTART: issue_cmd = i2c_pkg::CMD_START;
			S_CTRL:
			begin
				issue_cmd  = i2c_pkg::CMD_WRITE;
				issue_byte = eeprom_pkg::control_byte(xact_slot, 1'b0);
			end
			S_ADDR:
			begin
				issue_cmd  = i2c_pkg::CMD_WRITE;
				issue_byte = eeprom_pkg::word_addr(xact_slot);
			end
			S_WDATA:
			begin
				issue_cmd  = i2c_pkg::CMD_WRITE;
				issue_byte = wr_rec[8*(eeprom_pkg::RECORD_BYTES-1-int'(byte_cnt)) +: 8];
			end
			S_CTRL_RD:
			begin
				issue_cmd  = i2c_pkg::CMD_WRITE;
				issue_byte = eeprom_pkg::control_byte(xact_slot, 1'b1);
			end
			S_RDATA: issue_cmd = i2c_pkg::CMD_READ;
			S_STOP:  issue_cmd = i2c_pkg::CMD_STOP;
			default: issue_cmd = i2c_pkg::CMD_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= S_IDLE;
			pending  <= 1'b0;
			is_read  <= 1'b0;
			retry    <= 1'b0;
			byte_cnt <= '0;
			wr_slot  <= '0;
			rd_slot  <= '0;
			busy     <= 1'b0;
			end_o    <= 1'b0;
			data_out <= '0;
			seq.cmd  <= i2c_pkg::CMD_IDLE;
		end
		else
		begin
			seq.cmd <= i2c_pkg::CMD_IDLE;
			end_o   <= 1'b0;
			if (state == S_IDLE)
			begin
				if (write_start || read_start)
				begin
					is_read <= !write_start;	// write wins a tie
					retry   <= 1'b0;
					busy    <= 1'b1;
					state   <= S_START;
				end
			end
			else if (issue_now)
			begin
				seq.cmd <= issue_cmd;
				pending <= 1'b1;
			end
			else if (seq.done)
			begin
				pending <= 1'b0;
				if (abort)
				begin
					retry <= 1'b1;
					state <= S_STOP;
				end
				else
				begin
					case (state)
						S_START:   state <= S_CTRL;
						S_CTRL:    state <= S_ADDR;
						S_ADDR:
						begin
							byte_cnt <= '0;
							state    <= is_read ? S_RESTART : S_WDATA;
						end
						S_RESTART: state <= S_CTRL_RD;
						S_CTRL_RD:
						begin
							byte_cnt <= '0;
							state    <= S_RDATA;
						end
						S_WDATA, S_RDATA:
						begin
							if (byte_cnt == LAST_BYTE)
								state <= S_STOP;
							else
								byte_cnt <= byte_cnt + 1'b1;
						end
						default:
						begin
							if (retry)
							begin
								retry <= 1'b0;
								state <= S_START;	// whole record again
							end
							else
							begin
								busy  <= 1'b0;
								state <= S_IDLE;
								if (is_read)
								begin
									end_o    <= 1'b1;
									data_out <= rd_rec;
								end
								else
								begin
									rd_slot <= wr_slot;
									wr_slot <= (wr_slot == LAST_SLOT) ? '0 : wr_slot + 1'b1;
								end
							end
						end
					endcase
				end
			end
		end
	end

	// payload path
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && write_start)
			wr_rec <= data_in;
		if (issue_now)
		begin
			seq.tx_byte <= issue_byte;
			seq.ack_out <= (byte_cnt != LAST_BYTE);	// nack only the last byte
		end
		if (seq.done && state == S_RDATA)
			rd_rec <= {rd_rec[eeprom_pkg::RECORD_BYTES*8-9:0], seq.rx_byte};
	end

	// slot moves only when a write has just finished, and stays in range
	assert property (@(posedge clk) disable iff (!rst_n)
		(wr_slot != $past(wr_slot)) |->
			!busy && !is_read && rd_slot == $past(wr_slot) &&
			int'(wr_slot) < eeprom_pkg::SLOT_COUNT);

endmodule

`default_nettype wire

//--- logic/eeprom_record_ctrl.sv
/*
 * Top level of the 24LC04 record controller
 */
`timescale 1ns/1ps
`default_nettype none

module eeprom_record_ctrl #(
	parameter int CLK_DIV = 62	// clk cycles per quarter SCL period
) (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                write_start,
	input  wire logic                read_start,
	input  wire eeprom_pkg::record_t data_in,
	input  wire logic                sda_in,
	output wire logic                scl,
	output wire logic                sda_oe,	// high pulls sda low
	output wire logic                busy,
	output wire logic                end_o,
	output wire eeprom_pkg::record_t data_out
);

	i2c_byte_if u_byte_if ();

	record_sequencer u_record_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.write_start (write_start),
		.read_start  (read_start),
		.data_in     (data_in),
		.busy        (busy),
		.end_o       (end_o),
		.data_out    (data_out),
		.seq         (u_byte_if.seq)
	);

	i2c_bit_engine #(
		.CLK_DIV (CLK_DIV)
	) u_i2c_bit_engine (
		.clk    (clk),
		.rst_n  (rst_n),
		.sda_in (sda_in),
		.scl    (scl),
		.sda_oe (sda_oe),
		.eng    (u_byte_if.eng)
	);

endmodule

`default_nettype wire

//--- testbench/eeprom_model.sv
/*
 * Behavioral 24LC04 slave: 512 bytes in two blocks, 16-byte pages,
 * sequential reads and a count of acknowledges to refuse
 */
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
	input  wire logic scl,
	input  wire logic sda,
	output logic      sda_oe	// high pulls sda low
);

	logic [7:0] mem [0:511];
	int         nack_count;	// acknowledges still to refuse
	logic [8:0] addr;
	logic [7:0] shreg;
	logic [7:0] tx;
	int         bit_cnt;	// 8 is the ack slot
	int         byte_no;
	logic       active;
	logic       reading;
	logic       go_read;
	logic       skip_fall;	// first scl fall after a start
	logic       master_nack;

	initial
	begin
		nack_count  = 0;
		addr        = '0;
		bit_cnt     = 0;
		byte_no     = 0;
		active      = 1'b0;
		reading     = 1'b0;
		go_read     = 1'b0;
		skip_fall   = 1'b0;
		master_nack = 1'b0;
		sda_oe      = 1'b0;
	end

	// start or repeated start
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active    = 1'b1;
			reading   = 1'b0;
			go_read   = 1'b0;
			bit_cnt   = 0;
			byte_no   = 0;
			skip_fall = 1'b1;
			sda_oe    = 1'b0;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1)
		begin
			active  = 1'b0;	// stop
			reading = 1'b0;
			sda_oe  = 1'b0;
		end
	end

	always @(posedge scl)
	begin
		if (active && bit_cnt < 8 && !reading)
			shreg = {shreg[6:0], sda};
		else if (active && bit_cnt == 8 && reading)
			master_nack = sda;
	end

	always @(negedge scl)
	begin
		if (!active)
			sda_oe = 1'b0;
		else if (skip_fall)
			skip_fall = 1'b0;
		else if (bit_cnt < 7)
		begin
			bit_cnt = bit_cnt + 1;
			if (reading)
				sda_oe = ~tx[7 - bit_cnt];
		end
		else if (bit_cnt == 7)
		begin
			bit_cnt = 8;
			if (reading)
				sda_oe = 1'b0;	// master acks
			else if (nack_count > 0)
			begin
				nack_count = nack_count - 1;
				sda_oe     = 1'b0;
				active     = 1'b0;
			end
			else if (byte_no == 0)
			begin
				sda_oe  = (shreg[7:4] == 4'b1010);
				active  = (shreg[7:4] == 4'b1010);
				addr[8] = shreg[1];	// block bit
				go_read = shreg[0];
			end
			else
			begin
				sda_oe = 1'b1;
				if (byte_no == 1)
					addr[7:0] = shreg;
				else
				begin
					mem[addr] = shreg;
					addr[3:0] = addr[3:0] + 4'd1;	// page wrap
				end
			end
		end
		else
		begin
			// ack slot over
			bit_cnt = 0;
			byte_no = byte_no + 1;
			if ((reading && !master_nack) || go_read)
			begin
				reading = 1'b1;
				go_read = 1'b0;
				tx      = mem[addr];
				addr    = addr + 9'd1;
				sda_oe  = ~tx[7];
			end
			else
			begin
				if (reading)
					active = 1'b0;	// last byte, stop follows
				reading = 1'b0;
				sda_oe  = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_eeprom_record_ctrl.sv
/*
 * Testbench for the EEPROM record controller with tests from a data file,
 * a behavioral slave on a wired-AND SDA line, compare tasks and a timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_record_ctrl;

	localparam int CLK_DIV    = 4;
	localparam int CLK_PERIOD = 40;

	logic                clk;
	logic                rst_n;
	logic                write_start;
	logic                read_start;
	eeprom_pkg::record_t data_in;
	wire logic           scl;
	wire logic           dut_sda_oe;
	wire logic           model_sda_oe;
	wire logic           sda_bus;
	wire logic           busy;
	wire logic           end_o;
	wire eeprom_pkg::record_t data_out;

	logic [7:0]          ops[$];
	eeprom_pkg::record_t recs[$];
	int                  nacks[$];
	int                  reps[$];
	longint              cycle_cnt;
	longint              cycle_limit;

	assign sda_bus = !(dut_sda_oe || model_sda_oe);	// pull-up unless pulled low

	eeprom_record_ctrl #(
		.CLK_DIV (CLK_DIV)
	) u_eeprom_record_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.write_start (write_start),
		.read_start  (read_start),
		.data_in     (data_in),
		.sda_in      (sda_bus),
		.scl         (scl),
		.sda_oe      (dut_sda_oe),
		.busy        (busy),
		.end_o       (end_o),
		.data_out    (data_out)
	);

	eeprom_model u_model (
		.scl    (scl),
		.sda    (sda_bus),
		.sda_oe (model_sda_oe)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report(input string what);
		$display("%s at %0t ns", what, $time);
		stop_with_failure();
	endtask

	task automatic check_record(input string name, input eeprom_pkg::record_t got,
			input eeprom_pkg::record_t exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_byte(input int address, input i2c_pkg::bus_byte_t got,
			input i2c_pkg::bus_byte_t exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t mem[0x%03h]: got %h expected %h", $time, address, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// scl high and sda released while no transaction runs
	task automatic check_bus_idle();
		check_bit("scl", scl, 1'b1);
		check_bit("sda_oe", dut_sda_oe, 1'b0);
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// byte address where a slot starts in the 512-byte memory
	function automatic int slot_base(input int slot);
		return (slot / 16) * 256 + (slot % 16) * 16;
	endfunction

	task automatic load_tests();
		int                  fd;
		int                  n;
		int                  nk;
		int                  rp;
		string               line;
		logic [7:0]          op;
		eeprom_pkg::record_t rec;
		fd = $fopen("testbench/eeprom_tests.txt", "r");
		if (fd == 0)
			report("cannot open testbench/eeprom_tests.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%c %h %d %d", op, rec, nk, rp);
			if (n != 4 || (op != "W" && op != "R"))
				report("malformed line in the test file");
			ops.push_back(op);
			recs.push_back(rec);
			nacks.push_back(nk);
			reps.push_back(rp);
		end
		$fclose(fd);
	endtask

	// strobe once and repeat both strobes while the DUT is busy
	task automatic launch(input logic is_write, input eeprom_pkg::record_t rec);
		@(negedge clk);
		data_in     = rec;
		write_start = is_write;
		read_start  = !is_write;
		@(negedge clk);
		write_start = 1'b0;
		read_start  = 1'b0;
		check_bit("busy", busy, 1'b1);
		data_in     = ~rec;
		write_start = 1'b1;
		read_start  = 1'b1;
		@(negedge clk);
		write_start = 1'b0;
		read_start  = 1'b0;
	endtask

	task automatic run_write(input eeprom_pkg::record_t rec, input int nk, input int slot);
		int base;
		base = slot_base(slot);
		u_model.nack_count = nk;
		launch(1'b1, rec);
		while (busy)
		begin
			if (end_o)
				report("end_o pulsed during a write");
			@(negedge clk);
		end
		for (int i = 0; i < eeprom_pkg::RECORD_BYTES; i++)
			check_byte(base + i, u_model.mem[base + i], rec[8*(9-i) +: 8]);
		if (u_model.nack_count != 0)
			report("forced NACKs were not all taken by the write");
		check_bit("end_o", end_o, 1'b0);
		check_bus_idle();
	endtask

	task automatic run_read(input eeprom_pkg::record_t exp, input int nk);
		u_model.nack_count = nk;
		launch(1'b0, ~exp);
		while (!end_o)
		begin
			if (!busy)
				report("busy dropped without end_o on a read");
			@(negedge clk);
		end
		check_bit("busy", busy, 1'b0);
		check_record("data_out", data_out, exp);
		@(negedge clk);
		check_bit("end_o", end_o, 1'b0);
		check_record("data_out", data_out, exp);
		check_bus_idle();
		if (u_model.nack_count != 0)
			report("forced NACKs were not all taken by the read");
	endtask

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit)
			report("timeout, the DUT did not finish the tests");
	end

	// no bus activity outside a transaction
	always @(negedge scl)
	begin
		if (rst_n === 1'b1 && busy !== 1'b1)
			report("SCL toggled while the DUT was idle");
	end

	initial
	begin
		int          slot;
		int          total;
		logic [31:0] seed;
		write_start = 1'b0;
		read_start  = 1'b0;
		data_in     = '0;
		rst_n       = 1'b0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		load_tests();
		seed = 32'd98630;
		for (int i = 0; i < 512; i++)
		begin
			seed = lcg_next(seed);
			u_model.mem[i] = seed[23:16];	// stale contents
		end
		total = 0;
		foreach (reps[i])
			total += reps[i];
		cycle_limit = longint'(total) * 3 * 26 * 9 * 4 * CLK_DIV * 2;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("end_o", end_o, 1'b0);
		check_record("data_out", data_out, '0);
		check_bus_idle();
		slot = 0;
		foreach (ops[t])
		begin
			for (int r = 0; r < reps[t]; r++)
			begin
				if (ops[t] == "W")
				begin
					run_write(recs[t], nacks[t], slot);
					slot = (slot + 1) % eeprom_pkg::SLOT_COUNT;
				end
				else
					run_read(recs[t], nacks[t]);
			end
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/eeprom_tests.txt
# op record nack repeat: W writes record (first byte leftmost) repeat times
# R reads and expects record; nack = slave acknowledges refused first
W 0123456789abcdef0011 0 1
R 0123456789abcdef0011 0 1
W a5a55a5a0f0ff0f03c3c 0 1
R a5a55a5a0f0ff0f03c3c 0 1
W 11223344556677889900 1 1
R 11223344556677889900 0 1
W deadbeefcafef00d1234 0 1
R deadbeefcafef00d1234 2 1
W 00000000000000000000 0 1
R 00000000000000000000 0 1
W ffffffffffffffffffff 0 12
R ffffffffffffffffffff 0 1
W 8090a0b0c0d0e0f00102 2 1
R 8090a0b0c0d0e0f00102 1 1
W 13579bdf02468ace1122 0 14
R 13579bdf02468ace1122 0 2
W 0f1e2d3c4b5a69788796 0 1
R 0f1e2d3c4b5a69788796 0 1
W 55aa55aa55aa55aa55aa 1 1
R 55aa55aa55aa55aa55aa 1 1

//--- all.f
logic/i2c_pkg.sv
logic/eeprom_pkg.sv
logic/i2c_byte_if.sv
logic/i2c_bit_engine.sv
logic/record_sequencer.sv
logic/eeprom_record_ctrl.sv
testbench/eeprom_model.sv
testbench/tb_eeprom_record_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_eeprom_record_ctrl \
	-f all.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb
if [ $? -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
exit 0
